// ==== Bender.yml ====
package:
  name: cache_datapath

sources:
  # synthesizable cache data path
  - files:
      - cachePkg.sv
      - dataArray.sv
      - cacheTagStage.sv
      - cacheDataStage.sv
      - cacheTop.sv
  # testbench
  - target: test
    include_dirs:
      - .
    files:
      - tbCache.sv

// ==== cacheDataStage.sv ====
// data stage with data array writes for write hits and fills, read way select and the response register
`timescale 1ns/1ns

module cacheDataStage (
	input  logic clk,
	input  logic rst,
	// lookup record from the tag stage
	input  cachePkg::lookupT lookup,
	// registered response
	output cachePkg::cacheRespT resp
);

	// array control
	logic arrayWrite;

	// words read from both ways
	cachePkg::wordT dataWay0;
	cachePkg::wordT dataWay1;
	cachePkg::wordT hitWord;

	// decode of the lookup op
	logic isRead;
	logic isWrite;
	logic isFill;

	// next response
	cachePkg::cacheRespT nextResp;

	assign isRead = lookup.op == cachePkg::opRead;
	assign isWrite = lookup.op == cachePkg::opWrite;
	assign isFill = lookup.op == cachePkg::opFill;

	// write-through with no allocate, so a write miss leaves the array alone
	assign arrayWrite = lookup.valid && ((isWrite && lookup.hit) || isFill);

	dataArray u_dataArray (
		.clk      (clk),
		.rst      (rst),
		.write    (arrayWrite),
		.waySel   (lookup.way),
		.set      (lookup.set),
		.word     (lookup.word),
		.dataIn   (lookup.data),
		.dataWay0 (dataWay0),
		.dataWay1 (dataWay1)
	);

	// pick the way that matched
	assign hitWord = lookup.way ? dataWay1 : dataWay0;

	// reads and writes answer, fills stay silent
	always_comb begin
		nextResp.valid = lookup.valid && (isRead || isWrite);
		nextResp.hit = lookup.hit;
		// data only on a read hit, zero otherwise
		nextResp.data = (isRead && lookup.hit) ? hitWord : '0;
	end

	// response register
	always_ff @(posedge clk) begin
		resp <= nextResp;
		if (rst) begin
			resp.valid <= 1'b0;
		end
	end

endmodule

// ==== cachePkg.sv ====
// cache geometry constants, field width typedefs, operation enum and pipeline stage structs
package cachePkg;

	// word width in bits
	localparam int dataWidth = 16;

	// cache geometry
	localparam int numSets = 64;
	localparam int numWays = 2;
	localparam int wordsPerBlock = 8;

	// word address width, tag takes whatever set and offset leave over
	localparam int addrWidth = 16;
	localparam int setBits = $clog2(numSets);
	localparam int wordBits = $clog2(wordsPerBlock);
	localparam int tagBits = addrWidth - setBits - wordBits;

	// plain vectors for the fields that carry a meaning
	typedef logic [dataWidth-1:0] wordT;
	typedef logic [tagBits-1:0] tagT;
	typedef logic [setBits-1:0] setIdxT;
	typedef logic [wordBits-1:0] wordIdxT;
	// tag in the high bits, then set, then word offset
	typedef logic [addrWidth-1:0] addrT;

	// request operations
	typedef enum logic [1:0] {
		opRead,
		opWrite,
		opFill
	} cacheOpT;

	// one request entering the tag stage
	typedef struct packed {
		logic valid;
		cacheOpT op;
		tagT tag;
		setIdxT set;
		wordIdxT word;
		wordT data;
	} cacheReqT;

	// tag stage result handed to the data stage
	// way is only meaningful when hit is set
	typedef struct packed {
		logic valid;
		cacheOpT op;
		setIdxT set;
		wordIdxT word;
		wordT data;
		logic hit;
		logic way;
	} lookupT;

	// response seen at the top level
	typedef struct packed {
		logic valid;
		logic hit;
		wordT data;
	} cacheRespT;

endpackage

// ==== cacheTagStage.sv ====
// tag stage with tag, valid and LRU arrays, hit detection, victim choice and the lookup register
`timescale 1ns/1ns

module cacheTagStage (
	input  logic clk,
	input  logic rst,
	// incoming request, sampled every cycle
	input  cachePkg::cacheReqT req,
	// registered lookup record for the data stage
	output cachePkg::lookupT lookup
);

	// per-way tag storage
	cachePkg::tagT tagMem [cachePkg::numWays][cachePkg::numSets];

	// per-way valid bits, one per set
	logic [cachePkg::numSets-1:0] validBits [cachePkg::numWays];

	// one LRU bit per set
	// the bit names the way to evict next
	logic [cachePkg::numSets-1:0] lruBits;

	// way chosen by the first word of the current fill
	logic fillWay;

	// per-way tag match for the request set
	logic [cachePkg::numWays-1:0] wayHit;
	logic anyHit;
	logic hitWay;

	// victim for a fill start
	logic victim;

	// request decode
	logic isAccess;
	logic isFill;
	logic isFillStart;

	// next lookup record
	cachePkg::lookupT nextLookup;

	// tag compare against both ways
	always_comb begin
		for (int w = 0; w < cachePkg::numWays; w++) begin
			wayHit[w] = validBits[w][req.set] && (tagMem[w][req.set] == req.tag);
		end
	end

	assign anyHit = |wayHit;
	// way 0 wins if a tag ever sits in both ways
	assign hitWay = !wayHit[0];

	assign victim = lruBits[req.set];

	// reads and writes both do a lookup
	assign isAccess = req.valid && (req.op == cachePkg::opRead || req.op == cachePkg::opWrite);
	assign isFill = req.valid && (req.op == cachePkg::opFill);
	// offset 0 opens a new block fill
	assign isFillStart = isFill && (req.word == '0);

	// build the record handed to the data stage
	always_comb begin
		nextLookup.valid = req.valid;
		nextLookup.op = req.op;
		nextLookup.set = req.set;
		nextLookup.word = req.word;
		nextLookup.data = req.data;
		if (req.op == cachePkg::opFill) begin
			// fills always write, so they carry hit
			nextLookup.hit = 1'b1;
			// first word takes the victim, later words the remembered way
			nextLookup.way = (req.word == '0) ? victim : fillWay;
		end else begin
			nextLookup.hit = anyHit;
			nextLookup.way = hitWay;
		end
	end

	// tag install on a fill start
	always_ff @(posedge clk) begin
		if (isFillStart) begin
			tagMem[victim][req.set] <= req.tag;
		end
	end

	// valid bits
	always_ff @(posedge clk) begin
		if (rst) begin
			validBits <= '{default: '0};
		end else if (isFillStart) begin
			validBits[victim][req.set] <= 1'b1;
		end
	end

	// LRU bits point away from the way just used
	always_ff @(posedge clk) begin
		if (rst) begin
			lruBits <= '0;
		end else if (isFillStart) begin
			lruBits[req.set] <= !victim;
		end else if (isAccess && anyHit) begin
			lruBits[req.set] <= !hitWay;
		end
	end

	// remembered fill way
	always_ff @(posedge clk) begin
		if (rst) begin
			fillWay <= 1'b0;
		end else if (isFillStart) begin
			fillWay <= victim;
		end
	end

	// lookup register
	// payload loads every cycle, only the valid bit is cleared by reset
	always_ff @(posedge clk) begin
		lookup <= nextLookup;
		if (rst) begin
			lookup.valid <= 1'b0;
		end
	end

endmodule

// ==== cacheTop.sv ====
// cache top level that packs the request, chains the tag and data stages and unpacks the response
`timescale 1ns/1ns

module cacheTop (
	input  logic clk,
	input  logic rst,
	// request strobe and payload
	input  logic reqValid,
	input  cachePkg::cacheOpT reqOp,
	input  cachePkg::addrT reqAddr,
	input  cachePkg::wordT reqData,
	// response two cycles after the request
	output logic respValid,
	output logic respHit,
	output cachePkg::wordT respData
);

	// request into the tag stage
	cachePkg::cacheReqT req;

	// tag stage to data stage
	cachePkg::lookupT lookup;

	// data stage response
	cachePkg::cacheRespT resp;

	// request struct
	assign req.valid = reqValid;
	assign req.op = reqOp;
	assign req.data = reqData;
	// address splits into tag, set and word offset from the top down
	assign {req.tag, req.set, req.word} = reqAddr;

	// stage 1 does the lookup and updates tags and LRU
	cacheTagStage u_cacheTagStage (
		.clk    (clk),
		.rst    (rst),
		.req    (req),
		.lookup (lookup)
	);

	// stage 2 does the array access and builds the response
	cacheDataStage u_cacheDataStage (
		.clk    (clk),
		.rst    (rst),
		.lookup (lookup),
		.resp   (resp)
	);

	// response outputs
	assign respValid = resp.valid;
	assign respHit = resp.hit;
	assign respData = resp.data;

endmodule

// ==== dataArray.sv ====
// two-way data storage, 64 sets of 8 words, synchronous write and combinational read
`timescale 1ns/1ns

module dataArray (
	input  logic clk,
	input  logic rst,
	// write strobe and target way
	input  logic write,
	input  logic waySel,
	// shared location for both write and read
	input  cachePkg::setIdxT set,
	input  cachePkg::wordIdxT word,
	input  cachePkg::wordT dataIn,
	// read words of both ways at set and word
	output cachePkg::wordT dataWay0,
	output cachePkg::wordT dataWay1
);

	// one storage array per way, indexed by set then word
	cachePkg::wordT mem [cachePkg::numWays][cachePkg::numSets][cachePkg::wordsPerBlock];

	// way index taken from the single select bit
	logic wayIdx;

	assign wayIdx = waySel;

	// storage update
	// reset brings every word back to zero
	always_ff @(posedge clk) begin
		if (rst) begin
			mem <= '{default: '0};
		end else if (write) begin
			// only the selected way changes
			mem[wayIdx][set][word] <= dataIn;
		end
	end

	// both ways read at once, the data stage picks one
	assign dataWay0 = mem[0][set][word];
	assign dataWay1 = mem[1][set][word];

endmodule

// ==== filelist.f ====
+incdir+.
cachePkg.sv
dataArray.sv
cacheTagStage.sv
cacheDataStage.sv
cacheTop.sv
tbCache.sv

// ==== tbCacheModel.svh ====
// testbench reference model of tags, valid, LRU and data, xorshift source and compare tasks
`ifndef TB_CACHE_MODEL_SVH
`define TB_CACHE_MODEL_SVH

// expected response plus the cycle its request was driven in
typedef struct packed {
	logic hit;
	cachePkg::wordT data;
	logic [31:0] issueCycle;
} expectT;

// model copy of the cache contents
cachePkg::tagT modelTag [cachePkg::numWays][cachePkg::numSets];
logic modelValid [cachePkg::numWays][cachePkg::numSets];
// way to evict next, per set
logic modelLru [cachePkg::numSets];
logic modelFillWay;
cachePkg::wordT modelData [cachePkg::numWays][cachePkg::numSets][cachePkg::wordsPerBlock];

// xorshift state
logic [31:0] rngState = 32'h79ed;

// state right after reset: nothing valid, way 0 first victim, zero data
function automatic void resetModel();
	for (int w = 0; w < cachePkg::numWays; w++) begin
		for (int s = 0; s < cachePkg::numSets; s++) begin
			modelTag[w][s] = '0;
			modelValid[w][s] = 1'b0;
			for (int k = 0; k < cachePkg::wordsPerBlock; k++) begin
				modelData[w][s][k] = '0;
			end
		end
	end
	for (int s = 0; s < cachePkg::numSets; s++) begin
		modelLru[s] = 1'b0;
	end
	modelFillWay = 1'b0;
endfunction

// expected response of a read or write, updating LRU and data as the cache does
function automatic expectT predictAccess(input cachePkg::cacheOpT op,
		input cachePkg::addrT addr, input cachePkg::wordT data);
	cachePkg::tagT tag;
	cachePkg::setIdxT set;
	cachePkg::wordIdxT word;
	logic hit0;
	logic hit1;
	logic way;
	expectT e;
	{tag, set, word} = addr;
	hit0 = modelValid[0][set] && (modelTag[0][set] == tag);
	hit1 = modelValid[1][set] && (modelTag[1][set] == tag);
	// a tag present in both ways is served from way 0
	way = hit0 ? 1'b0 : 1'b1;
	e = '0;
	e.hit = hit0 || hit1;
	if (e.hit) begin
		modelLru[set] = !way;
		if (op == cachePkg::opWrite) begin
			modelData[way][set][word] = data;
		end else begin
			e.data = modelData[way][set][word];
		end
	end
	return e;
endfunction

// one fill word; offset 0 evicts the LRU way and installs the tag
function automatic void applyFill(input cachePkg::addrT addr, input cachePkg::wordT data);
	cachePkg::tagT tag;
	cachePkg::setIdxT set;
	cachePkg::wordIdxT word;
	{tag, set, word} = addr;
	if (word == '0) begin
		modelFillWay = modelLru[set];
		modelTag[modelFillWay][set] = tag;
		modelValid[modelFillWay][set] = 1'b1;
		modelLru[set] = !modelFillWay;
	end
	modelData[modelFillWay][set][word] = data;
endfunction

// 32-bit xorshift, shifts 13, 17, 5
function automatic logic [31:0] nextRandom();
	rngState = rngState ^ (rngState << 13);
	rngState = rngState ^ (rngState >> 17);
	rngState = rngState ^ (rngState << 5);
	return rngState;
endfunction

task automatic checkHit(input logic got, input logic exp);
	if (got !== exp) begin
		$display("CHECK FAILED at %0t ns: respHit got %0b expected %0b", $time, got, exp);
		stopOnError();
	end
endtask

task automatic checkData(input cachePkg::wordT got, input cachePkg::wordT exp);
	if (got !== exp) begin
		$display("CHECK FAILED at %0t ns: respData got %h expected %h", $time, got, exp);
		stopOnError();
	end
endtask

// cycles from driving a request to seeing respValid
task automatic checkLatency(input int got, input int exp);
	if (got != exp) begin
		$display("CHECK FAILED at %0t ns: respValid latency got %0d expected %0d",
			$time, got, exp);
		stopOnError();
	end
endtask

`endif

// ==== tbCache.sv ====
// testbench top with clock, reset, directed and random stimulus, response checker and watchdog
`timescale 1ns/1ns

module tbCache;

	localparam int resetCycles = 8;
	// upper bound on directed requests plus idle gaps
	localparam int directedOps = 120;
	// each random step is one access or one whole block fill
	localparam int randomSteps = 300;
	localparam int marginCycles = 100;
	localparam int timeLimit =
		(resetCycles + directedOps + randomSteps * cachePkg::wordsPerBlock + marginCycles) * 10;

	logic clk;
	logic rst;
	logic reqValid;
	cachePkg::cacheOpT reqOp;
	cachePkg::addrT reqAddr;
	cachePkg::wordT reqData;
	logic respValid;
	logic respHit;
	cachePkg::wordT respData;

	// rising edges seen so far
	int cycleCount = 0;
	logic [31:0] r;

	// first failing check ends the run
	task automatic stopOnError();
		$display("CHECKS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	`include "tbCacheModel.svh"

	// expected responses in request order
	expectT expQ [$];
	expectT head;

	cacheTop u_cacheTop (
		.clk       (clk),
		.rst       (rst),
		.reqValid  (reqValid),
		.reqOp     (reqOp),
		.reqAddr   (reqAddr),
		.reqData   (reqData),
		.respValid (respValid),
		.respHit   (respHit),
		.respData  (respData)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
	end

	function automatic cachePkg::addrT makeAddr(input cachePkg::tagT t,
			input cachePkg::setIdxT s, input cachePkg::wordIdxT w);
		return {t, s, w};
	endfunction

	// drive one request 1 ns after the edge and record what it should give
	task automatic issue(input cachePkg::cacheOpT op, input cachePkg::addrT addr,
			input cachePkg::wordT data);
		expectT e;
		@(posedge clk);
		#1;
		reqValid = 1'b1;
		reqOp = op;
		reqAddr = addr;
		reqData = data;
		if (op == cachePkg::opFill) begin
			applyFill(addr, data);
		end else begin
			e = predictAccess(op, addr, data);
			e.issueCycle = cycleCount;
			expQ.push_back(e);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			reqValid = 1'b0;
		end
	endtask

	// whole block, offsets 0 to 7 back to back
	task automatic fillBlock(input cachePkg::tagT t, input cachePkg::setIdxT s);
		for (int w = 0; w < cachePkg::wordsPerBlock; w++) begin
			issue(cachePkg::opFill, makeAddr(t, s, w), cachePkg::wordT'(nextRandom()));
		end
	endtask

	task automatic readBlock(input cachePkg::tagT t, input cachePkg::setIdxT s);
		for (int w = 0; w < cachePkg::wordsPerBlock; w++) begin
			issue(cachePkg::opRead, makeAddr(t, s, w), '0);
		end
	endtask

	// response checker, sampled at the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			if (respValid) begin
				if (expQ.size() == 0) begin
					$display("respValid rose at %0t ns with no request outstanding", $time);
					stopOnError();
				end else begin
					head = expQ.pop_front();
					checkLatency(cycleCount - int'(head.issueCycle), 2);
					checkHit(respHit, head.hit);
					checkData(respData, head.data);
				end
			end else if (expQ.size() != 0 && cycleCount - int'(expQ[0].issueCycle) > 2) begin
				$display("no response at %0t ns for a request driven in cycle %0d",
					$time, expQ[0].issueCycle);
				stopOnError();
			end
		end
	end

	initial begin
		#(timeLimit);
		$display("watchdog expired after %0d ns with the test still running", timeLimit);
		$display("CHECKS FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		rst = 1'b1;
		reqValid = 1'b0;
		reqOp = cachePkg::opRead;
		reqAddr = '0;
		reqData = '0;
		resetModel();
		repeat (resetCycles) @(posedge clk);
		#1;
		rst = 1'b0;

		// empty cache, every read misses with zero data
		for (int i = 0; i < 16; i++) begin
			issue(cachePkg::opRead, cachePkg::addrT'(nextRandom()), '0);
		end
		idle(3);

		// fill one block, then read it all back
		fillBlock(7'h05, 6'd3);
		readBlock(7'h05, 6'd3);
		// second block lands in way 1 of the same set
		fillBlock(7'h07, 6'd3);
		idle(3);

		// write hit followed at once by a read of the same word
		issue(cachePkg::opWrite, makeAddr(7'h05, 6'd3, 3'd2), cachePkg::wordT'(nextRandom()));
		issue(cachePkg::opRead, makeAddr(7'h05, 6'd3, 3'd2), '0);
		// write miss leaves both resident blocks alone
		issue(cachePkg::opWrite, makeAddr(7'h06, 6'd3, 3'd4), cachePkg::wordT'(nextRandom()));
		issue(cachePkg::opRead, makeAddr(7'h06, 6'd3, 3'd4), '0);
		issue(cachePkg::opRead, makeAddr(7'h05, 6'd3, 3'd4), '0);
		issue(cachePkg::opRead, makeAddr(7'h07, 6'd3, 3'd4), '0);
		idle(3);

		// LRU: touch the first tag so the third fill evicts the second
		fillBlock(7'h11, 6'd10);
		fillBlock(7'h22, 6'd10);
		issue(cachePkg::opRead, makeAddr(7'h11, 6'd10, 3'd0), '0);
		fillBlock(7'h33, 6'd10);
		for (int w = 0; w < 4; w++) begin
			issue(cachePkg::opRead, makeAddr(7'h22, 6'd10, w), '0);
			issue(cachePkg::opRead, makeAddr(7'h11, 6'd10, w), '0);
		end
		issue(cachePkg::opRead, makeAddr(7'h33, 6'd10, 3'd7), '0);
		idle(3);

		// random mix over 4 tags and 2 sets so hits and evictions are common
		for (int i = 0; i < randomSteps; i++) begin
			r = nextRandom();
			if (r[10:8] == 3'd0) begin
				fillBlock(7'h40 + r[1:0], 6'd20 + r[2]);
			end else if (r[10:8] < 3'd4) begin
				issue(cachePkg::opWrite, makeAddr(7'h40 + r[1:0], 6'd20 + r[2], r[5:3]),
					r[31:16]);
			end else begin
				issue(cachePkg::opRead, makeAddr(7'h40 + r[1:0], 6'd20 + r[2], r[5:3]), '0);
			end
		end
		idle(1);

		// let the pipeline drain
		while (expQ.size() != 0) begin
			@(negedge clk);
		end
		idle(2);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
